/* run_sim.sh */
#!/bin/sh
# build the clint testbench with verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module clint_tb -f sources.f -o clint_sim > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/clint_sim > sim.log 2>&1 || echo "simulator exited with an error status"
cat sim.log

grep -q "Finished with no errors" sim.log && exit 0 || exit 1

/* sources.f */
+incdir+src
src/axi_lite_pkg.sv
src/clint_pkg.sv
src/clint_reg_if.sv
src/axi_lite_slv_clint.sv
src/clint_mtime.sv
src/clint_irq_regs.sv
src/clint_top.sv
verification/clint_tb.sv

/* src/axi_lite_pkg.sv */
`default_nettype none

`include "clint_consts.svh"

package axi_lite_pkg;

    // only the two responses this slave can give
    typedef enum logic [`AXI_RESP_W-1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    // one transaction at a time
    typedef enum logic [1:0] {
        ST_IDLE   = 2'b00,
        ST_READ   = 2'b01,
        ST_AWRITE = 2'b10,
        ST_WRITE  = 2'b11
    } slv_state_e;

endpackage

`default_nettype wire

/* src/axi_lite_slv_clint.sv */
`timescale 1ns/10ps
`default_nettype none

`include "clint_consts.svh"

module axi_lite_slv_clint
    import axi_lite_pkg::*;
    import clint_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    // AR
    input  logic [`AXI_ADDR_W-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    // R
    output logic [`AXI_DATA_W-1:0] rdata,
    output logic [`AXI_RESP_W-1:0] rresp,
    output logic                   rvalid,
    input  logic                   rready,
    // AW
    input  logic [`AXI_ADDR_W-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    // W
    input  logic [`AXI_DATA_W-1:0] wdata,
    input  logic [`AXI_STRB_W-1:0] wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    // B
    output logic [`AXI_RESP_W-1:0] bresp,
    output logic                   bvalid,
    input  logic                   bready,
    clint_reg_if.ctrl              regs
);

    slv_state_e             state;
    slv_state_e             state_nxt;
    logic [`AXI_ADDR_W-1:0] addr_q;
    logic [`AXI_ADDR_W-1:0] offset;
    reg_sel_e               sel;
    axi_resp_e              acc_resp;
    logic [`AXI_DATA_W-1:0] rdata_q;
    axi_resp_e              rresp_q;
    axi_resp_e              bresp_q;
    logic                   rvalid_q;
    logic                   bvalid_q;
    logic                   ar_hs;
    logic                   aw_hs;
    logic                   w_hs;
    logic                   r_hs;
    logic                   b_hs;

    // AR wins over AW, so AW is held off while arvalid is up
    assign arready = (state == ST_IDLE);
    assign awready = (state == ST_IDLE) && !arvalid;
    assign wready  = (state == ST_AWRITE);

    assign ar_hs = arvalid && arready;
    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign r_hs  = rvalid_q && rready;
    assign b_hs  = bvalid_q && bready;

    // address decode from the latched address
    always_comb begin
        offset = addr_q - `CLINT_BASE;
        sel    = SEL_NONE;
        if (offset < `CLINT_SPAN) begin
            case (offset)
                `CLINT_OFF_MSIP:        sel = SEL_MSIP;
                `CLINT_OFF_MTIMECMP_LO: sel = SEL_MTIMECMP_LO;
                `CLINT_OFF_MTIMECMP_HI: sel = SEL_MTIMECMP_HI;
                `CLINT_OFF_MTIME_LO:    sel = SEL_MTIME_LO;
                `CLINT_OFF_MTIME_HI:    sel = SEL_MTIME_HI;
                default:                sel = SEL_NONE;
            endcase
        end
    end

    assign acc_resp = (sel == SEL_NONE) ? RESP_SLVERR : RESP_OKAY;

    // register port, write strobe lasts only the W transfer cycle
    assign regs.sel   = sel;
    assign regs.wr    = w_hs;
    assign regs.wdata = wdata;
    assign regs.wstrb = wstrb;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (ar_hs) begin
                    state_nxt = ST_READ;
                end else if (aw_hs) begin
                    state_nxt = ST_AWRITE;
                end
            end
            ST_READ: begin
                if (r_hs) begin
                    state_nxt = ST_IDLE;
                end
            end
            ST_AWRITE: begin
                if (w_hs) begin
                    state_nxt = ST_WRITE;
                end
            end
            ST_WRITE: begin
                if (b_hs) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            rvalid_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            state <= state_nxt;
            // read data is taken one cycle after AR
            if (state == ST_READ && !rvalid_q) begin
                rvalid_q <= 1'b1;
            end else if (r_hs) begin
                rvalid_q <= 1'b0;
            end
            if (w_hs) begin
                bvalid_q <= 1'b1;
            end else if (b_hs) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            addr_q <= araddr;
        end else if (aw_hs) begin
            addr_q <= awaddr;
        end
        if (state == ST_READ && !rvalid_q) begin
            rdata_q <= regs.rdata_time | regs.rdata_irq;
            rresp_q <= acc_resp;
        end
        if (w_hs) begin
            bresp_q <= acc_resp;
        end
    end

    assign rdata  = rdata_q;
    assign rresp  = rresp_q;
    assign rvalid = rvalid_q;
    assign bresp  = bresp_q;
    assign bvalid = bvalid_q;

    a_no_r_and_b: assert property (@(posedge clk) disable iff (!rst_n)
        !(rvalid && bvalid));

    // R payload holds under back-pressure
    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

    a_wr_in_awrite: assert property (@(posedge clk) disable iff (!rst_n)
        regs.wr |-> (state == ST_AWRITE) ##1 (state == ST_WRITE && bvalid));

endmodule

`default_nettype wire

/* src/clint_consts.svh */
`ifndef CLINT_CONSTS_SVH
`define CLINT_CONSTS_SVH

// axi-lite bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_STRB_W 4
`define AXI_RESP_W 2

// clint window
`define CLINT_BASE 32'ha000_0000
`define CLINT_SPAN 32'h0000_0100

// register offsets inside the window
`define CLINT_OFF_MSIP        32'h0000_0000
`define CLINT_OFF_MTIMECMP_LO 32'h0000_0040
`define CLINT_OFF_MTIMECMP_HI 32'h0000_0044
`define CLINT_OFF_MTIME_LO    32'h0000_0048
`define CLINT_OFF_MTIME_HI    32'h0000_004c

`endif

/* src/clint_irq_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "clint_consts.svh"

module clint_irq_regs
    import clint_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [63:0] mtime,
    clint_reg_if.irq    regs,
    output logic        mtip,
    output logic        msip
);

    logic [63:0] mtimecmp;
    logic        wr_cmp_lo;
    logic        wr_cmp_hi;
    logic        wr_msip;

    assign wr_cmp_lo = regs.wr && (regs.sel == SEL_MTIMECMP_LO);
    assign wr_cmp_hi = regs.wr && (regs.sel == SEL_MTIMECMP_HI);
    assign wr_msip   = regs.wr && (regs.sel == SEL_MSIP);

    // all ones keeps the timer quiet after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtimecmp <= '1;
        end else if (wr_cmp_lo) begin
            mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], regs.wdata, regs.wstrb);
        end else if (wr_cmp_hi) begin
            mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], regs.wdata, regs.wstrb);
        end
    end

    // only bit 0 exists, lives in byte lane 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            msip <= 1'b0;
        end else if (wr_msip && regs.wstrb[0]) begin
            msip <= regs.wdata[0];
        end
    end

    assign mtip = (mtime >= mtimecmp);

    always_comb begin
        case (regs.sel)
            SEL_MSIP:        regs.rdata_irq = {{(`AXI_DATA_W-1){1'b0}}, msip};
            SEL_MTIMECMP_LO: regs.rdata_irq = mtimecmp[31:0];
            SEL_MTIMECMP_HI: regs.rdata_irq = mtimecmp[63:32];
            default:         regs.rdata_irq = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/clint_mtime.sv */
`timescale 1ns/10ps
`default_nettype none

`include "clint_consts.svh"

module clint_mtime
    import clint_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    clint_reg_if.timer  regs,
    output logic [63:0] mtime
);

    logic wr_lo;
    logic wr_hi;

    assign wr_lo = regs.wr && (regs.sel == SEL_MTIME_LO);
    assign wr_hi = regs.wr && (regs.sel == SEL_MTIME_HI);

    // a write cycle replaces the count, no increment on it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime <= '0;
        end else if (wr_lo) begin
            mtime[31:0] <= merge_bytes(mtime[31:0], regs.wdata, regs.wstrb);
        end else if (wr_hi) begin
            mtime[63:32] <= merge_bytes(mtime[63:32], regs.wdata, regs.wstrb);
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    always_comb begin
        case (regs.sel)
            SEL_MTIME_LO: regs.rdata_time = mtime[31:0];
            SEL_MTIME_HI: regs.rdata_time = mtime[63:32];
            default:      regs.rdata_time = '0;
        endcase
    end

    a_mtime_inc: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_lo || wr_hi) |=> mtime == $past(mtime) + 64'd1);

endmodule

`default_nettype wire

/* src/clint_pkg.sv */
`default_nettype none

`include "clint_consts.svh"

package clint_pkg;

    typedef enum logic [2:0] {
        SEL_MSIP        = 3'd0,
        SEL_MTIMECMP_LO = 3'd1,
        SEL_MTIMECMP_HI = 3'd2,
        SEL_MTIME_LO    = 3'd3,
        SEL_MTIME_HI    = 3'd4,
        SEL_NONE        = 3'd7
    } reg_sel_e;

    // replace the strobed bytes of one bus word
    function automatic logic [`AXI_DATA_W-1:0] merge_bytes(
        input logic [`AXI_DATA_W-1:0] cur,
        input logic [`AXI_DATA_W-1:0] wdata,
        input logic [`AXI_STRB_W-1:0] wstrb
    );
        logic [`AXI_DATA_W-1:0] res;
        res = cur;
        for (int i = 0; i < `AXI_STRB_W; i++) begin
            if (wstrb[i]) begin
                res[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

/* src/clint_reg_if.sv */
`timescale 1ns/10ps
`default_nettype none

`include "clint_consts.svh"

interface clint_reg_if
    import clint_pkg::*;
();

    reg_sel_e              sel;
    logic                  wr;
    logic [`AXI_DATA_W-1:0] wdata;
    logic [`AXI_STRB_W-1:0] wstrb;

    // each block returns zero for selects it does not own
    logic [`AXI_DATA_W-1:0] rdata_time;
    logic [`AXI_DATA_W-1:0] rdata_irq;

    modport ctrl (
        output sel, wr, wdata, wstrb,
        input  rdata_time, rdata_irq
    );

    modport timer (
        input  sel, wr, wdata, wstrb,
        output rdata_time
    );

    modport irq (
        input  sel, wr, wdata, wstrb,
        output rdata_irq
    );

endinterface

`default_nettype wire

/* src/clint_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "clint_consts.svh"

module clint_top (
    input  logic                   clk,
    input  logic                   rst_n,
    // AR
    input  logic [`AXI_ADDR_W-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    // R
    output logic [`AXI_DATA_W-1:0] rdata,
    output logic [`AXI_RESP_W-1:0] rresp,
    output logic                   rvalid,
    input  logic                   rready,
    // AW
    input  logic [`AXI_ADDR_W-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    // W
    input  logic [`AXI_DATA_W-1:0] wdata,
    input  logic [`AXI_STRB_W-1:0] wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    // B
    output logic [`AXI_RESP_W-1:0] bresp,
    output logic                   bvalid,
    input  logic                   bready,
    // interrupts to the hart
    output logic                   mtip,
    output logic                   msip
);

    logic [63:0] mtime;

    clint_reg_if regs_if ();

    axi_lite_slv_clint axi_lite_slv_clint_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .regs    (regs_if.ctrl)
    );

    clint_mtime clint_mtime_i (
        .clk   (clk),
        .rst_n (rst_n),
        .regs  (regs_if.timer),
        .mtime (mtime)
    );

    clint_irq_regs clint_irq_regs_i (
        .clk   (clk),
        .rst_n (rst_n),
        .mtime (mtime),
        .regs  (regs_if.irq),
        .mtip  (mtip),
        .msip  (msip)
    );

endmodule

`default_nettype wire

/* verification/clint_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "clint_consts.svh"

module clint_tb;

    localparam int LIMIT = 200;
    localparam int M_NONE = 0;
    localparam int M_EXACT = 1;
    localparam int M_WINDOW = 2;
    localparam logic RD = 1'b0;
    localparam logic WR = 1'b1;
    localparam logic [1:0] OKAY = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;
    localparam logic [31:0] OFF_MSIP = `CLINT_OFF_MSIP;
    localparam logic [31:0] OFF_CMP_LO = `CLINT_OFF_MTIMECMP_LO;
    localparam logic [31:0] OFF_CMP_HI = `CLINT_OFF_MTIMECMP_HI;
    localparam logic [31:0] OFF_TIME_LO = `CLINT_OFF_MTIME_LO;
    localparam logic [31:0] OFF_TIME_HI = `CLINT_OFF_MTIME_HI;

    logic        clk;
    logic        rst_n;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic        mtip;
    logic        msip;

    // one row per bus operation, t_data is wdata for writes and the expected rdata for reads
    logic        t_wr   [0:39];
    logic [31:0] t_off  [0:39];
    logic [31:0] t_data [0:39];
    logic [3:0]  t_strb [0:39];
    int          t_mode [0:39];
    logic [1:0]  t_resp [0:39];
    logic        t_irq  [0:39];
    logic        t_mtip [0:39];
    logic        t_msip [0:39];
    string       t_name [0:39];
    int          n_rows = 0;

    logic [15:0] lfsr = 16'd24;
    logic [31:0] cyc = '0;
    logic [31:0] w_cyc;
    logic [31:0] r_cyc;
    logic        row_fail;
    logic        aborted = 1'b0;
    int          n_pass = 0;
    int          n_fail = 0;

    clint_top clint_top_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // galois form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hb400;
        end
        return n;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    function automatic logic [31:0] apply_strobes(input logic [31:0] old_val,
        input logic [31:0] new_val, input logic [3:0] strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    function automatic logic sig_high(input int which);
        case (which)
            0: return arready;
            1: return rvalid;
            2: return awready;
            3: return wready;
            default: return bvalid;
        endcase
    endfunction

    task automatic wait_sig(input int which, input string what);
        int n;
        n = 0;
        while (!sig_high(which) && !aborted) begin
            if (n == LIMIT) begin
                $display("timeout after %0d cycles waiting for %s at %0t ns", LIMIT, what, $time);
                aborted = 1'b1;
                row_fail = 1'b1;
            end else begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Error at %0t ns: %s expected 0x%08h, actual 0x%08h", $time, what, exp, act);
            row_fail = 1'b1;
        end
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
        output logic [1:0] resp);
        logic [31:0] d0;
        logic [1:0]  r0;
        int          hold;
        data = '0;
        resp = '0;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        wait_sig(0, "arready");
        @(negedge clk);
        arvalid = 1'b0;
        wait_sig(1, "rvalid");
        if (aborted) begin
            return;
        end
        d0   = rdata;
        r0   = rresp;
        hold = int'(rand_bits(2));
        // R must not move while rready is low
        repeat (hold) begin
            @(negedge clk);
            check_val("rvalid", 32'd1, {31'd0, rvalid});
            check_val("rdata", d0, rdata);
            check_val("rresp", {30'd0, r0}, {30'd0, rresp});
        end
        rready = 1'b1;
        data   = rdata;
        resp   = rresp;
        r_cyc  = cyc;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
        input logic [3:0] strb, output logic [1:0] resp);
        logic [1:0] r0;
        int         hold;
        resp = '0;
        @(negedge clk);
        awaddr  = addr;
        awvalid = 1'b1;
        wait_sig(2, "awready");
        @(negedge clk);
        awvalid = 1'b0;
        wdata   = data;
        wstrb   = strb;
        wvalid  = 1'b1;
        wait_sig(3, "wready");
        // the W transfer lands on the next rising edge
        w_cyc = cyc;
        @(negedge clk);
        wvalid = 1'b0;
        wait_sig(4, "bvalid");
        if (aborted) begin
            return;
        end
        r0   = bresp;
        hold = int'(rand_bits(2));
        repeat (hold) begin
            @(negedge clk);
            check_val("bvalid", 32'd1, {31'd0, bvalid});
            check_val("bresp", {30'd0, r0}, {30'd0, bresp});
        end
        bready = 1'b1;
        resp   = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic add_row(input logic wr, input logic [31:0] off, input logic [31:0] data,
        input logic [3:0] strb, input int mode, input logic [1:0] resp, input string name);
        t_wr[n_rows]   = wr;
        t_off[n_rows]  = off;
        t_data[n_rows] = data;
        t_strb[n_rows] = strb;
        t_mode[n_rows] = mode;
        t_resp[n_rows] = resp;
        t_name[n_rows] = name;
        t_irq[n_rows]  = 1'b0;
        t_mtip[n_rows] = 1'b0;
        t_msip[n_rows] = 1'b0;
        n_rows++;
    endtask

    // interrupt levels expected after the latest row
    task automatic expect_irq(input logic mtip_exp, input logic msip_exp);
        t_irq[n_rows-1]  = 1'b1;
        t_mtip[n_rows-1] = mtip_exp;
        t_msip[n_rows-1] = msip_exp;
    endtask

    task automatic build_table();
        logic [31:0] cmp_lo;
        logic [31:0] cmp_hi;
        logic [31:0] time_hi;
        logic [31:0] d;
        logic [3:0]  s;
        cmp_lo  = 32'hffff_ffff;
        cmp_hi  = 32'hffff_ffff;
        // differs from the reset value so the upper half write shows up
        time_hi = 32'h0000_0003;
        add_row(RD, OFF_CMP_LO, cmp_lo, 4'h0, M_EXACT, OKAY, "reset mtimecmp lo");
        add_row(RD, OFF_CMP_HI, cmp_hi, 4'h0, M_EXACT, OKAY, "reset mtimecmp hi");
        add_row(RD, OFF_MSIP, 32'h0, 4'h0, M_EXACT, OKAY, "reset msip");
        expect_irq(1'b0, 1'b0);
        d = rand_bits(32);
        cmp_lo = d;
        add_row(WR, OFF_CMP_LO, d, 4'hf, M_NONE, OKAY, "mtimecmp lo full write");
        add_row(RD, OFF_CMP_LO, cmp_lo, 4'h0, M_EXACT, OKAY, "mtimecmp lo readback");
        d = rand_bits(32);
        cmp_hi = d;
        add_row(WR, OFF_CMP_HI, d, 4'hf, M_NONE, OKAY, "mtimecmp hi full write");
        add_row(RD, OFF_CMP_HI, cmp_hi, 4'h0, M_EXACT, OKAY, "mtimecmp hi readback");
        // partial strobes, never empty or full
        d = rand_bits(32);
        s = 4'(rand_bits(4));
        if (s == 4'h0 || s == 4'hf) begin
            s = 4'h6;
        end
        cmp_lo = apply_strobes(cmp_lo, d, s);
        add_row(WR, OFF_CMP_LO, d, s, M_NONE, OKAY, "mtimecmp lo partial write");
        add_row(RD, OFF_CMP_LO, cmp_lo, 4'h0, M_EXACT, OKAY, "mtimecmp lo merged");
        d = rand_bits(32);
        s = 4'(rand_bits(4));
        if (s == 4'h0 || s == 4'hf) begin
            s = 4'h9;
        end
        cmp_hi = apply_strobes(cmp_hi, d, s);
        add_row(WR, OFF_CMP_HI, d, s, M_NONE, OKAY, "mtimecmp hi partial write");
        add_row(RD, OFF_CMP_HI, cmp_hi, 4'h0, M_EXACT, OKAY, "mtimecmp hi merged");
        add_row(WR, OFF_TIME_HI, time_hi, 4'hf, M_NONE, OKAY, "mtime hi write");
        add_row(WR, OFF_TIME_LO, 32'h0000_1000, 4'hf, M_NONE, OKAY, "mtime lo write");
        add_row(RD, OFF_TIME_LO, 32'h0000_1000, 4'h0, M_WINDOW, OKAY, "mtime first read");
        add_row(RD, OFF_TIME_LO, 32'h0000_1000, 4'h0, M_WINDOW, OKAY, "mtime second read");
        add_row(RD, OFF_TIME_HI, time_hi, 4'h0, M_EXACT, OKAY, "mtime hi read");
        // compare value a few dozen cycles ahead of mtime
        add_row(WR, OFF_TIME_LO, 32'h0000_2000, 4'hf, M_NONE, OKAY, "mtime lo rewrite");
        add_row(WR, OFF_CMP_HI, time_hi, 4'hf, M_NONE, OKAY, "mtimecmp hi match");
        add_row(WR, OFF_CMP_LO, 32'h0000_2040, 4'hf, M_NONE, OKAY, "mtimecmp near mtime");
        expect_irq(1'b1, 1'b0);
        cmp_lo = 32'hffff_ffff;
        cmp_hi = 32'hffff_ffff;
        add_row(WR, OFF_CMP_LO, cmp_lo, 4'hf, M_NONE, OKAY, "mtimecmp lo all ones");
        add_row(WR, OFF_CMP_HI, cmp_hi, 4'hf, M_NONE, OKAY, "mtimecmp hi all ones");
        expect_irq(1'b0, 1'b0);
        add_row(WR, OFF_MSIP, 32'h1, 4'h1, M_NONE, OKAY, "msip set");
        expect_irq(1'b0, 1'b1);
        add_row(RD, OFF_MSIP, 32'h1, 4'h0, M_EXACT, OKAY, "msip readback");
        add_row(WR, OFF_MSIP, 32'h0, 4'h1, M_NONE, OKAY, "msip clear");
        expect_irq(1'b0, 1'b0);
        add_row(RD, 32'h0000_0080, 32'h0, 4'h0, M_EXACT, SLVERR, "unmapped read");
        add_row(WR, 32'h0000_0090, rand_bits(32), 4'hf, M_NONE, SLVERR, "unmapped write");
        add_row(RD, OFF_CMP_LO, cmp_lo, 4'h0, M_EXACT, OKAY, "mtimecmp after unmapped");
        add_row(RD, 32'h0000_0104, 32'h0, 4'h0, M_EXACT, SLVERR, "read outside window");
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] hi_bound;
        logic [31:0] ref_cyc;
        logic [31:0] prev;
        logic [1:0]  resp;
        logic        have_prev;
        int          n;
        rst_n     = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        ref_cyc   = '0;
        prev      = '0;
        have_prev = 1'b0;
        build_table();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            if (!aborted) begin
                row_fail = 1'b0;
                if (t_wr[i]) begin
                    bus_write(`CLINT_BASE + t_off[i], t_data[i], t_strb[i], resp);
                    if (t_off[i] == OFF_TIME_LO) begin
                        ref_cyc   = w_cyc;
                        have_prev = 1'b0;
                    end
                    if (!aborted) begin
                        check_val("bresp", {30'd0, t_resp[i]}, {30'd0, resp});
                    end
                end else begin
                    bus_read(`CLINT_BASE + t_off[i], data, resp);
                    if (!aborted) begin
                        check_val("rresp", {30'd0, t_resp[i]}, {30'd0, resp});
                        if (t_mode[i] == M_EXACT) begin
                            check_val("rdata", t_data[i], data);
                        end else if (t_mode[i] == M_WINDOW) begin
                            hi_bound = t_data[i] + (r_cyc - ref_cyc);
                            assert (data >= t_data[i] && data <= hi_bound) else begin
                                $display("Error at %0t ns: mtime expected 0x%08h to 0x%08h, %s",
                                    $time, t_data[i], hi_bound, $sformatf("actual 0x%08h", data));
                                row_fail = 1'b1;
                            end
                            assert (!have_prev || data > prev) else begin
                                $display("Error at %0t ns: mtime expected above 0x%08h, %s",
                                    $time, prev, $sformatf("actual 0x%08h", data));
                                row_fail = 1'b1;
                            end
                            prev      = data;
                            have_prev = 1'b1;
                        end
                    end
                end
                if (t_irq[i] && !aborted) begin
                    n = 0;
                    while ({mtip, msip} != {t_mtip[i], t_msip[i]} && n < LIMIT) begin
                        @(negedge clk);
                        n++;
                    end
                    check_val("mtip", {31'd0, t_mtip[i]}, {31'd0, mtip});
                    check_val("msip", {31'd0, t_msip[i]}, {31'd0, msip});
                end
                if (row_fail) begin
                    n_fail++;
                end else begin
                    n_pass++;
                end
                $display("test %0d %s: %s", i, t_name[i], row_fail ? "FAILED" : "ok");
            end
        end
        $display("tests %0d, passed %0d, failed %0d, skipped %0d",
            n_rows, n_pass, n_fail, n_rows - n_pass - n_fail);
        if (n_fail == 0 && !aborted) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
